// File: design/trig_command_out.sv
`timescale 1ns/1ps

module trig_command_out (
    input  logic                              sysclk_i,
    input  logic                              rst_n_i,
    input  logic                              evt_valid_i,
    input  logic [trig_pkg::EVT_ADDR_W-1:0]   evt_addr_i,
    input  logic [trig_pkg::TRIG_TIME_W-1:0]  evt_time_i,
    input  logic [trig_pkg::META_W-1:0]       evt_meta_i,
    input  logic                              cmd_ack_i,
    output logic                              busy_o,
    output logic [trig_pkg::CMD_W-1:0]        cmd_o,
    output logic                              cmd_req_o
);
    import trig_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,
        ST_REQ      = 2'd1,
        ST_WAIT_REL = 2'd2
    } state_t;

    state_t state_q;
    state_t state_d;

    // four-phase sequence: raise req, drop it on ack, wait for ack to drop
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (evt_valid_i) begin
                    state_d = ST_REQ;
                end
            end
            ST_REQ: begin
                if (cmd_ack_i) begin
                    state_d = ST_WAIT_REL;
                end
            end
            ST_WAIT_REL: begin
                if (!cmd_ack_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // only loaded from idle, so it stays put for the whole request
    always_ff @(posedge sysclk_i) begin
        if ((state_q == ST_IDLE) && evt_valid_i) begin
            cmd_o <= {evt_addr_i, evt_time_i, evt_meta_i};
        end
    end

    assign cmd_req_o = (state_q == ST_REQ);
    // covers the event clock itself so a second event can't slip in
    assign busy_o    = evt_valid_i | (state_q != ST_IDLE);

endmodule

// File: design/trig_holdoff_ctrl.sv
`timescale 1ns/1ps

module trig_holdoff_ctrl #(
    parameter int HOLDOFF = 12
) (
    input  logic                              sysclk_i,
    input  logic                              rst_n_i,
    input  logic                              run_en_i,
    input  logic                              cand_i,
    input  logic [trig_pkg::TRIG_TIME_W-1:0]  cand_time_i,
    input  logic [trig_pkg::META_W-1:0]       cand_meta_i,
    input  logic                              busy_i,
    output logic                              evt_valid_o,
    output logic [trig_pkg::EVT_ADDR_W-1:0]   evt_addr_o,
    output logic [trig_pkg::TRIG_TIME_W-1:0]  evt_time_o,
    output logic [trig_pkg::META_W-1:0]       evt_meta_o,
    output logic [trig_pkg::DROP_CNT_W-1:0]   dropped_o
);
    import trig_pkg::*;

    localparam int HO_W = $clog2(HOLDOFF + 1);

    logic [HO_W-1:0]       holdoff_q;
    logic [EVT_ADDR_W-1:0] evt_num_q;
    logic                  accept;
    logic                  refuse;

    // a candidate with run enabled is either taken or counted as dropped
    assign accept = cand_i & run_en_i & (holdoff_q == '0) & ~busy_i;
    assign refuse = cand_i & run_en_i & ((holdoff_q != '0) | busy_i);

    // counts down to zero, the next trigger may go on the clock it reaches zero
    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            holdoff_q <= '0;
        end else if (accept) begin
            holdoff_q <= HO_W'(HOLDOFF - 1);
        end else if (holdoff_q != '0) begin
            holdoff_q <= holdoff_q - 1'b1;
        end
    end

    // event number restarts at 0 for every run
    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            evt_num_q <= '0;
        end else if (!run_en_i) begin
            evt_num_q <= '0;
        end else if (accept) begin
            evt_num_q <= evt_num_q + 1'b1;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            evt_valid_o <= 1'b0;
        end else begin
            evt_valid_o <= accept;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (accept) begin
            evt_addr_o <= evt_num_q;
            evt_time_o <= cand_time_i;
            evt_meta_o <= cand_meta_i;
        end
    end

    // saturates instead of wrapping
    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            dropped_o <= '0;
        end else if (refuse && (dropped_o != '1)) begin
            dropped_o <= dropped_o + 1'b1;
        end
    end

endmodule

// File: design/trig_input_merge.sv
`timescale 1ns/1ps

module trig_input_merge #(
    parameter int NSURF = 8
) (
    input  logic                                     sysclk_i,
    input  logic                                     rst_n_i,
    input  logic                                     sysclk_phase_i,
    input  logic [NSURF*trig_pkg::BOARD_WORD_W-1:0]  trig_dat_i,
    input  logic [NSURF-1:0]                         trig_mask_i,
    output logic                                     cand_o,
    output logic [trig_pkg::TRIG_TIME_W-1:0]         cand_time_o,
    output logic [trig_pkg::META_W-1:0]              cand_meta_o
);
    import trig_pkg::*;

    board_word_u            words [NSURF];
    logic [NSURF-1:0]       hit_q;
    logic [TRIG_TIME_W-1:0] time_q [NSURF];
    logic                   phase_d_q;
    logic                   sel_any;
    logic [TRIG_TIME_W-1:0] sel_time;
    logic [META_W-1:0]      sel_meta;

    // split the flat bus into per-board words
    for (genvar g = 0; g < NSURF; g++) begin : g_word
        assign words[g] = trig_dat_i[g*BOARD_WORD_W +: BOARD_WORD_W];
    end

    // phase clock carries the trigger words, the clock after it the metadata
    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            phase_d_q <= 1'b0;
            hit_q     <= '0;
        end else begin
            phase_d_q <= sysclk_phase_i;
            if (sysclk_phase_i) begin
                for (int i = 0; i < NSURF; i++) begin
                    hit_q[i] <= words[i].trig.is_trig & ~trig_mask_i[i];
                end
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (sysclk_phase_i) begin
            for (int i = 0; i < NSURF; i++) begin
                time_q[i] <= words[i].trig.trig_time;
            end
        end
    end

    // lowest index wins, so walk downward and let the last match stick
    always_comb begin
        sel_any  = 1'b0;
        sel_time = '0;
        sel_meta = '0;
        for (int i = NSURF - 1; i >= 0; i--) begin
            if (hit_q[i]) begin
                sel_any  = 1'b1;
                sel_time = time_q[i];
                sel_meta = words[i].meta.meta;
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            cand_o <= 1'b0;
        end else begin
            cand_o <= phase_d_q & sel_any;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (phase_d_q) begin
            cand_time_o <= sel_time;
            cand_meta_o <= sel_meta;
        end
    end

endmodule

// File: design/trig_master_top.sv
`timescale 1ns/1ps

module trig_master_top #(
    parameter int NSURF   = 8,
    parameter int HOLDOFF = 12
) (
    input  logic                                     sysclk_i,
    input  logic                                     rst_n_i,
    input  logic                                     sysclk_phase_i,
    input  logic [NSURF*trig_pkg::BOARD_WORD_W-1:0]  trig_dat_i,
    input  logic [NSURF-1:0]                         trig_mask_i,
    input  logic                                     run_en_i,
    input  logic                                     cmd_ack_i,
    output logic [trig_pkg::CMD_W-1:0]               cmd_o,
    output logic                                     cmd_req_o,
    output logic [trig_pkg::DROP_CNT_W-1:0]          dropped_o
);
    import trig_pkg::*;

    logic                   cand;
    logic [TRIG_TIME_W-1:0] cand_time;
    logic [META_W-1:0]      cand_meta;
    logic                   evt_valid;
    logic [EVT_ADDR_W-1:0]  evt_addr;
    logic [TRIG_TIME_W-1:0] evt_time;
    logic [META_W-1:0]      evt_meta;
    logic                   busy;

    trig_input_merge #(
        .NSURF(NSURF)
    ) u_merge (
        .sysclk_i       (sysclk_i),
        .rst_n_i        (rst_n_i),
        .sysclk_phase_i (sysclk_phase_i),
        .trig_dat_i     (trig_dat_i),
        .trig_mask_i    (trig_mask_i),
        .cand_o         (cand),
        .cand_time_o    (cand_time),
        .cand_meta_o    (cand_meta)
    );

    trig_holdoff_ctrl #(
        .HOLDOFF(HOLDOFF)
    ) u_holdoff (
        .sysclk_i    (sysclk_i),
        .rst_n_i     (rst_n_i),
        .run_en_i    (run_en_i),
        .cand_i      (cand),
        .cand_time_i (cand_time),
        .cand_meta_i (cand_meta),
        .busy_i      (busy),
        .evt_valid_o (evt_valid),
        .evt_addr_o  (evt_addr),
        .evt_time_o  (evt_time),
        .evt_meta_o  (evt_meta),
        .dropped_o   (dropped_o)
    );

    trig_command_out u_cmd (
        .sysclk_i    (sysclk_i),
        .rst_n_i     (rst_n_i),
        .evt_valid_i (evt_valid),
        .evt_addr_i  (evt_addr),
        .evt_time_i  (evt_time),
        .evt_meta_i  (evt_meta),
        .cmd_ack_i   (cmd_ack_i),
        .busy_o      (busy),
        .cmd_o       (cmd_o),
        .cmd_req_o   (cmd_req_o)
    );

endmodule

// File: design/trig_pkg.sv
package trig_pkg;

    // widths of the words moving through the trigger path
    localparam int BOARD_WORD_W = 16;
    localparam int TRIG_TIME_W  = 12;
    localparam int META_W       = 8;
    localparam int EVT_ADDR_W   = 12;
    localparam int CMD_W        = 32;
    localparam int DROP_CNT_W   = 16;

    // first word of a board's command cycle, top bit set
    typedef struct packed {
        logic                   is_trig;
        logic [2:0]             rsvd;
        logic [TRIG_TIME_W-1:0] trig_time;
    } trig_view_t;

    // second word of the cycle, top bit clear
    typedef struct packed {
        logic              is_trig;
        logic [6:0]        rsvd;
        logic [META_W-1:0] meta;
    } meta_view_t;

    // one board word, read as either view depending on the cycle
    typedef union packed {
        trig_view_t trig;
        meta_view_t meta;
    } board_word_u;

endpackage

// File: run_sim.sh
#!/bin/sh
# build and run the trigger master testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f trig_master_top.f \
    --top-module trig_master_tb \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/Vtrig_master_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: trig_master_top.f
design/trig_pkg.sv
design/trig_input_merge.sv
design/trig_holdoff_ctrl.sv
design/trig_command_out.sv
design/trig_master_top.sv
verification/trig_master_chk.sv
verification/trig_master_tb.sv

// File: verification/trig_master_chk.sv
`timescale 1ns/1ps

module trig_master_chk (
    input logic                       sysclk_i,
    input logic                       rst_n_i,
    input logic                       cmd_req_o,
    input logic                       cmd_ack_i,
    input logic [trig_pkg::CMD_W-1:0] cmd_o
);

    // number of assertion failures so far
    int unsigned n_fail = 0;

    // request holds until the link acknowledges
    a_req_hold: assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
        cmd_req_o && !cmd_ack_i |=> cmd_req_o)
        else begin
            n_fail++;
            $error("cmd_req_o fell before cmd_ack_i");
        end

    a_cmd_stable: assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
        cmd_req_o |=> !cmd_req_o || $stable(cmd_o))
        else begin
            n_fail++;
            $error("cmd_o changed during a request");
        end

    // no new request until the previous ack is released
    a_no_early_req: assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
        !cmd_req_o && cmd_ack_i |=> !cmd_req_o)
        else begin
            n_fail++;
            $error("cmd_req_o rose while cmd_ack_i was high");
        end

    a_reset_idle: assert property (@(posedge sysclk_i)
        !rst_n_i |=> !cmd_req_o)
        else begin
            n_fail++;
            $error("cmd_req_o high during reset");
        end

endmodule

bind trig_command_out trig_master_chk u_chk (
    .sysclk_i  (sysclk_i),
    .rst_n_i   (rst_n_i),
    .cmd_req_o (cmd_req_o),
    .cmd_ack_i (cmd_ack_i),
    .cmd_o     (cmd_o)
);

// File: verification/trig_master_tb.sv
`timescale 1ns/1ps

module trig_master_tb;
    import trig_pkg::*;

    localparam int NSURF   = 8;
    localparam int HOLDOFF = 12;
    localparam int DAT_W   = NSURF * BOARD_WORD_W;
    // phase cycles over all tests, with slack for the handshake drains
    localparam int N_PHASE = 280;

    logic               sysclk_i = 1'b0;
    logic               rst_n_i;
    logic               sysclk_phase_i;
    logic [DAT_W-1:0]   trig_dat_i;
    logic [NSURF-1:0]   trig_mask_i;
    logic               run_en_i;
    logic               cmd_ack_i;
    logic [CMD_W-1:0]   cmd_o;
    logic               cmd_req_o;
    logic [DROP_CNT_W-1:0] dropped_o;

    logic [CMD_W-1:0]      exp_q [$];
    int                    delay_q [$];
    int                    cmd_errs;
    int                    drop_errs;
    int                    proto_errs;
    int                    assert_errs;
    logic [EVT_ADDR_W-1:0] evt_num;
    logic [DROP_CNT_W-1:0] drops;
    int                    pclk;
    int                    last_p;
    int                    gap;
    bit                    have_last;
    logic                  req_prev;

    trig_master_top #(.NSURF(NSURF), .HOLDOFF(HOLDOFF)) DUT (.*);

    initial begin
        forever #50 sysclk_i = ~sysclk_i;
    end

    // lowest unmasked board with its trigger flag set gives time and metadata
    function automatic logic [CMD_W:0] expected_cmd(input logic [DAT_W-1:0] trig_w,
            input logic [DAT_W-1:0] meta_w, input logic [NSURF-1:0] mask,
            input logic [EVT_ADDR_W-1:0] num);
        board_word_u   tw;
        board_word_u   mw;
        logic [CMD_W:0] res;
        res = '0;
        for (int i = 0; i < NSURF; i++) begin
            tw = trig_w[i*BOARD_WORD_W +: BOARD_WORD_W];
            mw = meta_w[i*BOARD_WORD_W +: BOARD_WORD_W];
            if (!res[CMD_W] && tw.trig.is_trig && !mask[i]) begin
                res = {1'b1, num, tw.trig.trig_time, mw.meta.meta};
            end
        end
        return res;
    endfunction

    task automatic check_cmd(input logic [CMD_W-1:0] got, input logic [CMD_W-1:0] exp);
        if (got !== exp) begin
            cmd_errs++;
            $display("Fail %0t: cmd_o %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_drops(input logic [DROP_CNT_W-1:0] got,
            input logic [DROP_CNT_W-1:0] exp);
        if (got !== exp) begin
            drop_errs++;
            $display("Fail %0t: dropped_o %0d, expected %0d", $time, got, exp);
        end
    endtask

    // one 8-clock command cycle; the model predicts acceptance at phase edge + 2
    task automatic run_cycle(input logic [DAT_W-1:0] trig_w, input logic [DAT_W-1:0] meta_w,
            input logic [NSURF-1:0] mask, input logic run_en, input int ack_dly);
        logic [CMD_W:0] r;
        for (int c = 0; c < 8; c++) begin
            @(posedge sysclk_i);
            #1;
            sysclk_phase_i = (c == 0);
            trig_dat_i     = (c == 0) ? trig_w : (c == 1) ? meta_w : DAT_W'({4{$urandom()}});
            if (c == 0) begin
                trig_mask_i = mask;
                run_en_i    = run_en;
            end
            if (c == 1) begin
                r = expected_cmd(trig_w, meta_w, mask, evt_num);
                if (!run_en) begin
                    evt_num = '0;
                end else if (r[CMD_W]) begin
                    if (!have_last || (pclk - last_p >= gap)) begin
                        exp_q.push_back(r[CMD_W-1:0]);
                        delay_q.push_back(ack_dly);
                        evt_num   = evt_num + 12'd1;
                        last_p    = pclk;
                        // busy ends 6 clocks plus the ack delay after acceptance
                        gap       = (6 + ack_dly > HOLDOFF) ? 6 + ack_dly : HOLDOFF;
                        have_last = 1'b1;
                    end else if (drops != '1) begin
                        drops = drops + 16'd1;
                    end
                end
            end
        end
        pclk += 8;
    endtask

    function automatic logic [DAT_W-1:0] make_trig(input logic [NSURF-1:0] sel);
        logic [DAT_W-1:0] w;
        for (int i = 0; i < NSURF; i++) begin
            w[i*BOARD_WORD_W +: BOARD_WORD_W] = {sel[i], 3'b000, 12'($urandom())};
        end
        return w;
    endfunction

    function automatic logic [DAT_W-1:0] make_meta();
        logic [DAT_W-1:0] w;
        for (int i = 0; i < NSURF; i++) begin
            w[i*BOARD_WORD_W +: BOARD_WORD_W] = {8'h00, 8'($urandom())};
        end
        return w;
    endfunction

    // every command the model expected must have been requested once the link is quiet
    task automatic drain_and_check();
        while (cmd_req_o || cmd_ack_i) begin
            @(posedge sysclk_i);
        end
        repeat (8) @(posedge sysclk_i);
        if (exp_q.size() != 0) begin
            proto_errs++;
            $display("%0t: %0d expected commands were never requested", $time, exp_q.size());
            exp_q.delete();
            delay_q.delete();
        end
        check_drops(dropped_o, drops);
    endtask

    // ack responder takes its delay from the model's queue
    initial begin
        int d;
        cmd_ack_i = 1'b0;
        forever begin
            @(posedge sysclk_i);
            if (cmd_req_o) begin
                d = (delay_q.size() != 0) ? delay_q.pop_front() : 0;
                repeat (d) @(posedge sysclk_i);
                #1 cmd_ack_i = 1'b1;
                do @(posedge sysclk_i); while (cmd_req_o);
                #1 cmd_ack_i = 1'b0;
            end
        end
    end

    // compare on each rising request
    initial begin
        req_prev = 1'b0;
        forever begin
            @(posedge sysclk_i);
            if (cmd_req_o && !req_prev) begin
                if (exp_q.size() == 0) begin
                    proto_errs++;
                    $display("%0t: a command was requested that the model did not expect",
                             $time);
                end else begin
                    check_cmd(cmd_o, exp_q.pop_front());
                end
            end
            req_prev = cmd_req_o;
        end
    end

    initial begin
        #(N_PHASE * 8 * 100 + 20000);
        $display("watchdog expired, the run did not finish in time");
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [DAT_W-1:0] tw;
        void'($urandom(32'hb642_b073));
        rst_n_i = 1'b0;
        sysclk_phase_i = 1'b0;
        trig_dat_i = '0;
        trig_mask_i = '0;
        run_en_i = 1'b0;
        cmd_errs = 0;
        drop_errs = 0;
        proto_errs = 0;
        assert_errs = 0;
        evt_num = '0;
        drops = '0;
        pclk = 0;
        have_last = 1'b0;
        gap = HOLDOFF;
        repeat (16) @(posedge sysclk_i);
        #1 rst_n_i = 1'b1;
        // triggers 16 clocks apart
        for (int k = 0; k < 3; k++) begin
            run_cycle(make_trig(NSURF'($urandom())), make_meta(), '0, 1'b1, 2);
            run_cycle(make_trig('0), make_meta(), '0, 1'b1, 2);
        end
        drain_and_check();
        // masked boards, cleared flags, and a mixed mask
        run_cycle(make_trig(8'h08), make_meta(), 8'h08, 1'b1, 1);
        run_cycle(make_trig('0), make_meta(), '0, 1'b1, 1);
        run_cycle(make_trig(8'h52), make_meta(), 8'h02, 1'b1, 1);
        run_cycle(make_trig('0), make_meta(), '0, 1'b1, 1);
        drain_and_check();
        // back to back phases, every second one falls in holdoff
        for (int k = 0; k < 8; k++) begin
            run_cycle(make_trig(8'h01), make_meta(), '0, 1'b1, 0);
        end
        drain_and_check();
        // slow ack keeps the output busy
        for (int k = 0; k < 8; k++) begin
            run_cycle(make_trig(8'h80), make_meta(), '0, 1'b1, 20);
        end
        drain_and_check();
        // run disabled, then a fresh run
        for (int k = 0; k < 3; k++) begin
            run_cycle(make_trig(8'hff), make_meta(), '0, 1'b0, 0);
        end
        for (int k = 0; k < 3; k++) begin
            run_cycle(make_trig(8'h10), make_meta(), '0, 1'b1, 0);
            run_cycle(make_trig('0), make_meta(), '0, 1'b1, 0);
        end
        drain_and_check();
        // random run
        for (int k = 0; k < 200; k++) begin
            tw = make_trig(NSURF'($urandom() & $urandom()));
            run_cycle(tw, make_meta(), NSURF'($urandom() & $urandom()),
                      ($urandom() % 16) != 0, $urandom() % 16);
        end
        drain_and_check();
        assert_errs = DUT.u_cmd.u_chk.n_fail;
        $display("errors: cmd=%0d drops=%0d protocol=%0d assert=%0d",
                 cmd_errs, drop_errs, proto_errs, assert_errs);
        if (cmd_errs + drop_errs + proto_errs + assert_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
